// ==== logic/vec_defs.svh ====
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Register file geometry
`define VEC_NR_REGS    8
// One bank per element, so this is also the element count of a register
`define VEC_NR_BANKS   4
`define VEC_ELEM_W     32

//////////////////////////////////////////////////////////////////////
// Wishbone register map

// Word address width of the slave port
`define VEC_WB_ADR_W   8

// 0x00 to 0x1F are vector elements, register * 4 + element
`define VEC_ADR_CMD    8'h20
`define VEC_ADR_STATUS 8'h21

`endif

// ==== logic/vec_pkg.sv ====
`include "vec_defs.svh"

package vec_pkg;

  // Index types
  typedef logic [$clog2(`VEC_NR_REGS)-1:0]  vreg_idx_t;
  typedef logic [$clog2(`VEC_NR_BANKS)-1:0] velem_idx_t;

  // Register index above element index
  typedef logic [$bits(vreg_idx_t)+$bits(velem_idx_t)-1:0] vreg_addr_t;

  // Element payload and its byte enables
  typedef logic [`VEC_ELEM_W-1:0]   velem_t;
  typedef logic [`VEC_ELEM_W/8-1:0] vbe_t;

  // Encoding matches bits 1:0 of the command word
  typedef enum logic [1:0] {
    VOP_ADD = 2'd0,
    VOP_SUB = 2'd1,
    VOP_AND = 2'd2,
    VOP_XOR = 2'd3
  } vop_e;

  typedef enum logic [1:0] {VFU_IDLE, VFU_RUN, VFU_DRAIN} vfu_state_e;

  typedef enum logic [1:0] {WBP_IDLE, WBP_ACCESS, WBP_ACK} wbp_state_e;

endpackage

// ==== logic/vec_regfile_bank.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_regfile_bank
  import vec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  // Write port
  input  vreg_idx_t waddr_i,
  input  velem_t    wdata_i,
  input  logic      we_i,
  input  vbe_t      wbe_i,
  // Read ports
  input  vreg_idx_t raddr0_i,
  input  vreg_idx_t raddr1_i,
  output velem_t    rdata0_o,
  output velem_t    rdata1_o
);

  // One element of every vector register
  velem_t mem [`VEC_NR_REGS];

  //////////////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_REGS; r++) begin
        mem[r] <= '0;
      end
    end else if (we_i) begin
      // Only enabled byte lanes take the new data
      for (int b = 0; b < $bits(vbe_t); b++) begin
        if (wbe_i[b]) begin
          mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports

  // Both ports are plain muxes, no read latency
  assign rdata0_o = mem[raddr0_i];
  assign rdata1_o = mem[raddr1_i];

endmodule

// ==== logic/vec_vrf.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_vrf
  import vec_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  // Functional unit, always wins
  input  vreg_addr_t vfu_vs1_addr_i,
  input  vreg_addr_t vfu_vs2_addr_i,
  input  vreg_addr_t vfu_vd_addr_i,
  input  logic       vfu_re_i,
  input  logic       vfu_we_i,
  input  velem_t     vfu_wdata_i,
  output velem_t     vfu_vs1_o,
  output velem_t     vfu_vs2_o,
  // Host, second priority
  input  vreg_addr_t host_addr_i,
  input  logic       host_re_i,
  input  logic       host_we_i,
  input  velem_t     host_wdata_i,
  input  vbe_t       host_wbe_i,
  output velem_t     host_rdata_o,
  output logic       host_rgnt_o,
  output logic       host_wgnt_o
);

  // Element index in the low bits picks the bank
  function automatic velem_idx_t bank_of(vreg_addr_t addr);
    return addr[$bits(velem_idx_t)-1:0];
  endfunction

  function automatic vreg_idx_t reg_of(vreg_addr_t addr);
    return addr[$bits(vreg_addr_t)-1:$bits(velem_idx_t)];
  endfunction

  velem_t                   bank_rdata0 [`VEC_NR_BANKS];
  velem_t                   bank_rdata1 [`VEC_NR_BANKS];
  logic [`VEC_NR_BANKS-1:0] host_rgnt_bank;
  logic [`VEC_NR_BANKS-1:0] host_wgnt_bank;

  //////////////////////////////////////////////////////////////////////
  // Per bank port mapping

  for (genvar b = 0; b < `VEC_NR_BANKS; b++) begin : gen_bank
    vreg_idx_t raddr0;
    vreg_idx_t raddr1;
    vreg_idx_t waddr;
    velem_t    wdata;
    vbe_t      wbe;
    logic      we;
    logic      rgnt;
    logic      wgnt;

    // Port 0 is reserved for vs2
    always_comb begin
      raddr0 = '0;
      if (vfu_re_i && bank_of(vfu_vs2_addr_i) == velem_idx_t'(b)) begin
        raddr0 = reg_of(vfu_vs2_addr_i);
      end
    end

    // Port 1 serves vs1 ahead of the host
    always_comb begin
      raddr1 = '0;
      rgnt   = 1'b0;
      if (vfu_re_i && bank_of(vfu_vs1_addr_i) == velem_idx_t'(b)) begin
        raddr1 = reg_of(vfu_vs1_addr_i);
      end else if (host_re_i && bank_of(host_addr_i) == velem_idx_t'(b)) begin
        raddr1 = reg_of(host_addr_i);
        rgnt   = 1'b1;
      end
    end

    // Write port, vd ahead of the host
    always_comb begin
      waddr = '0;
      wdata = '0;
      wbe   = '0;
      we    = 1'b0;
      wgnt  = 1'b0;
      if (vfu_we_i && bank_of(vfu_vd_addr_i) == velem_idx_t'(b)) begin
        waddr = reg_of(vfu_vd_addr_i);
        wdata = vfu_wdata_i;
        wbe   = '1;
        we    = 1'b1;
      end else if (host_we_i && bank_of(host_addr_i) == velem_idx_t'(b)) begin
        waddr = reg_of(host_addr_i);
        wdata = host_wdata_i;
        wbe   = host_wbe_i;
        we    = 1'b1;
        wgnt  = 1'b1;
      end
    end

    assign host_rgnt_bank[b] = rgnt;
    assign host_wgnt_bank[b] = wgnt;

    vec_regfile_bank i_bank (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .waddr_i  (waddr),
      .wdata_i  (wdata),
      .we_i     (we),
      .wbe_i    (wbe),
      .raddr0_i (raddr0),
      .raddr1_i (raddr1),
      .rdata0_o (bank_rdata0[b]),
      .rdata1_o (bank_rdata1[b])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Return paths

  assign vfu_vs2_o = bank_rdata0[bank_of(vfu_vs2_addr_i)];
  assign vfu_vs1_o = bank_rdata1[bank_of(vfu_vs1_addr_i)];

  assign host_rgnt_o  = |host_rgnt_bank;
  assign host_wgnt_o  = |host_wgnt_bank;
  assign host_rdata_o = host_rgnt_o ? bank_rdata1[bank_of(host_addr_i)] : '0;

endmodule

// ==== logic/vec_vfu.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_vfu
  import vec_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  // Command
  input  logic       start_i,
  input  vop_e       op_i,
  input  vreg_idx_t  vd_i,
  input  vreg_idx_t  vs1_i,
  input  vreg_idx_t  vs2_i,
  output logic       busy_o,
  // Register file side
  output vreg_addr_t vs1_addr_o,
  output vreg_addr_t vs2_addr_o,
  output vreg_addr_t vd_addr_o,
  output logic       re_o,
  output logic       we_o,
  output velem_t     wdata_o,
  input  velem_t     vs1_i_data,
  input  velem_t     vs2_i_data
);

  localparam velem_idx_t last_elem = velem_idx_t'(`VEC_NR_BANKS - 1);

  vfu_state_e state_q;
  velem_idx_t ridx_q;
  velem_idx_t widx_q;
  vop_e       op_q;
  vreg_idx_t  vd_q;
  vreg_idx_t  vs1_q;
  vreg_idx_t  vs2_q;
  velem_t     res_q;
  velem_t     alu_res;
  logic       accept;

  assign accept = start_i && (state_q == VFU_IDLE);

  //////////////////////////////////////////////////////////////////////
  // Element sequencer

  // Writes trail reads by one element, so vd may alias a source
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= VFU_IDLE;
      ridx_q  <= '0;
      widx_q  <= '0;
    end else begin
      case (state_q)
        VFU_IDLE: begin
          if (accept) begin
            state_q <= VFU_RUN;
            ridx_q  <= '0;
          end
        end
        VFU_RUN: begin
          widx_q <= ridx_q;
          ridx_q <= ridx_q + 1'b1;
          if (ridx_q == last_elem) begin
            state_q <= VFU_DRAIN;
          end
        end
        VFU_DRAIN: state_q <= VFU_IDLE;
        default:   state_q <= VFU_IDLE;
      endcase
    end
  end

  // Latched command and result pipeline register
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= op_i;
      vd_q  <= vd_i;
      vs1_q <= vs1_i;
      vs2_q <= vs2_i;
    end
    if (state_q == VFU_RUN) begin
      res_q <= alu_res;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath

  // Sub follows the RVV order, vs2 minus vs1
  always_comb begin
    case (op_q)
      VOP_ADD: alu_res = vs2_i_data + vs1_i_data;
      VOP_SUB: alu_res = vs2_i_data - vs1_i_data;
      VOP_AND: alu_res = vs2_i_data & vs1_i_data;
      VOP_XOR: alu_res = vs2_i_data ^ vs1_i_data;
      default: alu_res = '0;
    endcase
  end

  assign busy_o = (state_q != VFU_IDLE);
  assign re_o   = (state_q == VFU_RUN);
  // No result is pending yet while element 0 is read
  assign we_o   = ((state_q == VFU_RUN) && (ridx_q != '0)) || (state_q == VFU_DRAIN);

  assign vs1_addr_o = {vs1_q, ridx_q};
  assign vs2_addr_o = {vs2_q, ridx_q};
  assign vd_addr_o  = {vd_q, widx_q};
  assign wdata_o    = res_q;

endmodule

// ==== logic/vec_wb_port.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_wb_port
  import vec_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n_i,
  // Wishbone classic slave
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`VEC_WB_ADR_W-1:0] wb_adr_i,
  input  velem_t                   wb_dat_i,
  input  vbe_t                     wb_sel_i,
  output velem_t                   wb_dat_o,
  output logic                     wb_ack_o,
  // Functional unit command
  input  logic                     busy_i,
  output logic                     start_o,
  output vop_e                     op_o,
  output vreg_idx_t                vd_o,
  output vreg_idx_t                vs1_o,
  output vreg_idx_t                vs2_o,
  // Host port of the register file
  output vreg_addr_t               host_addr_o,
  output logic                     host_re_o,
  output logic                     host_we_o,
  output velem_t                   host_wdata_o,
  output vbe_t                     host_wbe_o,
  input  velem_t                   host_rdata_i,
  input  logic                     host_rgnt_i,
  input  logic                     host_wgnt_i
);

  wbp_state_e state_q;
  logic       req;
  logic       new_req;
  logic       is_elem;
  logic       is_cmd;
  logic       is_status;
  logic       granted;
  velem_t     reg_rdata;

  //////////////////////////////////////////////////////////////////////
  // Address decode

  assign req       = wb_cyc_i && wb_stb_i;
  assign new_req   = req && (state_q == WBP_IDLE);
  assign is_elem   = wb_adr_i < `VEC_WB_ADR_W'(`VEC_NR_REGS * `VEC_NR_BANKS);
  assign is_cmd    = (wb_adr_i == `VEC_ADR_CMD);
  assign is_status = (wb_adr_i == `VEC_ADR_STATUS);

  // Command reads and unmapped reads return zero
  assign reg_rdata = is_status ? velem_t'(busy_i) : '0;

  // Command word fields
  assign op_o  = vop_e'(wb_dat_i[1:0]);
  assign vd_o  = wb_dat_i[4:2];
  assign vs1_o = wb_dat_i[7:5];
  assign vs2_o = wb_dat_i[10:8];

  // Dropped while the unit is busy, the transfer is still acked
  assign start_o = new_req && wb_we_i && is_cmd && !busy_i;

  //////////////////////////////////////////////////////////////////////
  // Element access

  // Master holds its signals, so the request is driven straight from them
  assign host_addr_o  = wb_adr_i[$bits(vreg_addr_t)-1:0];
  assign host_re_o    = (state_q == WBP_ACCESS) && !wb_we_i;
  assign host_we_o    = (state_q == WBP_ACCESS) && wb_we_i;
  assign host_wdata_o = wb_dat_i;
  assign host_wbe_o   = wb_sel_i;

  assign granted = (host_re_o && host_rgnt_i) || (host_we_o && host_wgnt_i);

  //////////////////////////////////////////////////////////////////////
  // Transfer FSM

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= WBP_IDLE;
    end else begin
      case (state_q)
        WBP_IDLE: begin
          if (req) begin
            state_q <= is_elem ? WBP_ACCESS : WBP_ACK;
          end
        end
        WBP_ACCESS: begin
          // Abandoned cycle, give up the request
          if (!req) begin
            state_q <= WBP_IDLE;
          end else if (granted) begin
            state_q <= WBP_ACK;
          end
        end
        WBP_ACK: state_q <= WBP_IDLE;
        default: state_q <= WBP_IDLE;
      endcase
    end
  end

  // Read data lines up with the ack cycle
  always_ff @(posedge clk) begin
    if (new_req && !is_elem) begin
      wb_dat_o <= reg_rdata;
    end else if (host_re_o && host_rgnt_i) begin
      wb_dat_o <= host_rdata_i;
    end
  end

  assign wb_ack_o = (state_q == WBP_ACK);

endmodule

// ==== logic/vec_cluster.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_cluster
  import vec_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n_i,
  // Wishbone classic slave
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`VEC_WB_ADR_W-1:0] wb_adr_i,
  input  velem_t                   wb_dat_i,
  input  vbe_t                     wb_sel_i,
  output velem_t                   wb_dat_o,
  output logic                     wb_ack_o
);

  // Command path
  logic       busy;
  logic       start;
  vop_e       op;
  vreg_idx_t  vd;
  vreg_idx_t  vs1;
  vreg_idx_t  vs2;

  // Host element path
  vreg_addr_t host_addr;
  logic       host_re;
  logic       host_we;
  velem_t     host_wdata;
  vbe_t       host_wbe;
  velem_t     host_rdata;
  logic       host_rgnt;
  logic       host_wgnt;

  // Functional unit element path
  vreg_addr_t vfu_vs1_addr;
  vreg_addr_t vfu_vs2_addr;
  vreg_addr_t vfu_vd_addr;
  logic       vfu_re;
  logic       vfu_we;
  velem_t     vfu_wdata;
  velem_t     vfu_vs1_data;
  velem_t     vfu_vs2_data;

  vec_wb_port i_wb_port (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .busy_i       (busy),
    .start_o      (start),
    .op_o         (op),
    .vd_o         (vd),
    .vs1_o        (vs1),
    .vs2_o        (vs2),
    .host_addr_o  (host_addr),
    .host_re_o    (host_re),
    .host_we_o    (host_we),
    .host_wdata_o (host_wdata),
    .host_wbe_o   (host_wbe),
    .host_rdata_i (host_rdata),
    .host_rgnt_i  (host_rgnt),
    .host_wgnt_i  (host_wgnt)
  );

  vec_vfu i_vfu (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .op_i       (op),
    .vd_i       (vd),
    .vs1_i      (vs1),
    .vs2_i      (vs2),
    .busy_o     (busy),
    .vs1_addr_o (vfu_vs1_addr),
    .vs2_addr_o (vfu_vs2_addr),
    .vd_addr_o  (vfu_vd_addr),
    .re_o       (vfu_re),
    .we_o       (vfu_we),
    .wdata_o    (vfu_wdata),
    .vs1_i_data (vfu_vs1_data),
    .vs2_i_data (vfu_vs2_data)
  );

  vec_vrf i_vrf (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .vfu_vs1_addr_i (vfu_vs1_addr),
    .vfu_vs2_addr_i (vfu_vs2_addr),
    .vfu_vd_addr_i  (vfu_vd_addr),
    .vfu_re_i       (vfu_re),
    .vfu_we_i       (vfu_we),
    .vfu_wdata_i    (vfu_wdata),
    .vfu_vs1_o      (vfu_vs1_data),
    .vfu_vs2_o      (vfu_vs2_data),
    .host_addr_i    (host_addr),
    .host_re_i      (host_re),
    .host_we_i      (host_we),
    .host_wdata_i   (host_wdata),
    .host_wbe_i     (host_wbe),
    .host_rdata_o   (host_rdata),
    .host_rgnt_o    (host_rgnt),
    .host_wgnt_o    (host_wgnt)
  );

endmodule

// ==== sim/tb_vec_cluster.sv ====
`timescale 1ns/1ps
`include "vec_defs.svh"

module tb_vec_cluster
  import vec_pkg::*;
();

  localparam int nr_elems     = `VEC_NR_REGS * `VEC_NR_BANKS;
  localparam int ack_timeout  = 64;
  localparam int poll_timeout = 32;

  logic                     clk;
  logic                     rst_n_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`VEC_WB_ADR_W-1:0] wb_adr_i;
  velem_t                   wb_dat_i;
  vbe_t                     wb_sel_i;
  velem_t                   wb_dat_o;
  logic                     wb_ack_o;

  // Reference copy of every element indexed by register * 4 + element
  velem_t      model [nr_elems];
  logic [31:0] lfsr;

  vec_cluster dut (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random data and checks

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(string name, velem_t exp, velem_t act);
    assert (act === exp) else begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
      abort_run();
    end
  endtask

  // Element-wise rule with vs2 as the first operand
  function automatic velem_t op_result(vop_e op, velem_t a, velem_t b);
    case (op)
      VOP_ADD: return a + b;
      VOP_SUB: return a - b;
      VOP_AND: return a & b;
      default: return a ^ b;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Wishbone host

  task automatic wb_transfer(input logic we, input logic [`VEC_WB_ADR_W-1:0] adr,
                             input velem_t dat, input vbe_t sel, output velem_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    // Ack and data are looked at mid cycle
    @(negedge clk);
    while (!wb_ack_o && waited < ack_timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (wb_ack_o) else begin
      $display("No Wishbone ack within %0d cycles at address 0x%02h", ack_timeout, adr);
      abort_run();
    end
    rdata = wb_dat_o;
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    assert (!wb_ack_o) else begin
      $display("Wishbone ack stayed high for more than one cycle at 0x%02h", adr);
      abort_run();
    end
  endtask

  task automatic elem_write(int idx, velem_t dat, vbe_t sel);
    velem_t unused;
    wb_transfer(1'b1, `VEC_WB_ADR_W'(idx), dat, sel, unused);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        model[idx][8*b +: 8] = dat[8*b +: 8];
      end
    end
  endtask

  task automatic elem_check(int idx);
    velem_t rd;
    wb_transfer(1'b0, `VEC_WB_ADR_W'(idx), '0, '0, rd);
    check_word($sformatf("wb_dat_o element 0x%02h", idx), model[idx], rd);
  endtask

  task automatic check_all();
    for (int i = 0; i < nr_elems; i++) begin
      elem_check(i);
    end
  endtask

  task automatic issue_cmd(vop_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2);
    velem_t unused;
    wb_transfer(1'b1, `VEC_ADR_CMD, {21'b0, vs2, vs1, vd, op}, 4'hf, unused);
  endtask

  // Element k of the result only uses element k of the sources
  task automatic model_op(vop_e op, int vd, int vs1, int vs2);
    for (int k = 0; k < `VEC_NR_BANKS; k++) begin
      model[vd*4+k] = op_result(op, model[vs2*4+k], model[vs1*4+k]);
    end
  endtask

  task automatic wait_idle();
    velem_t st;
    int     polls;
    polls = 0;
    wb_transfer(1'b0, `VEC_ADR_STATUS, '0, '0, st);
    while (st[0] && polls < poll_timeout) begin
      wb_transfer(1'b0, `VEC_ADR_STATUS, '0, '0, st);
      polls++;
    end
    assert (!st[0]) else begin
      $display("Functional unit still busy after %0d status polls", polls);
      abort_run();
    end
    check_word("wb_dat_o status", 32'h0, st);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    velem_t rd;
    int     idx;
    lfsr     = 32'hf99b_119e;
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    for (int i = 0; i < nr_elems; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // Reset state and unmapped space
    @(negedge clk);
    assert (!wb_ack_o) else begin
      $display("Wishbone ack is high right after reset");
      abort_run();
    end
    wait_idle();
    check_all();
    wb_transfer(1'b1, 8'h22, rand_bits(32), 4'hf, rd);
    wb_transfer(1'b1, 8'hff, rand_bits(32), 4'hf, rd);
    wb_transfer(1'b0, 8'h22, '0, '0, rd);
    check_word("wb_dat_o unmapped 0x22", 32'h0, rd);
    wb_transfer(1'b0, 8'hff, '0, '0, rd);
    check_word("wb_dat_o unmapped 0xff", 32'h0, rd);
    check_all();

    // Full words and then byte lanes
    for (int i = 0; i < nr_elems; i++) begin
      elem_write(i, rand_bits(32), 4'hf);
    end
    check_all();
    elem_write(9, rand_bits(32), 4'b0101);
    for (int n = 0; n < 12; n++) begin
      idx = int'(rand_bits(5));
      elem_write(idx, rand_bits(32), vbe_t'(rand_bits(4)));
    end
    check_all();

    // One command per opcode where the last one overwrites its own vs1
    issue_cmd(VOP_ADD, 3'd2, 3'd0, 3'd1);
    model_op(VOP_ADD, 2, 0, 1);
    // The unit is still running when this status read is sampled
    wb_transfer(1'b0, `VEC_ADR_STATUS, '0, '0, rd);
    check_word("wb_dat_o status busy", 32'h1, rd);
    wait_idle();
    check_all();
    issue_cmd(VOP_SUB, 3'd3, 3'd1, 3'd0);
    model_op(VOP_SUB, 3, 1, 0);
    wait_idle();
    check_all();
    issue_cmd(VOP_AND, 3'd4, 3'd2, 3'd3);
    model_op(VOP_AND, 4, 2, 3);
    wait_idle();
    check_all();
    issue_cmd(VOP_XOR, 3'd5, 3'd5, 3'd4);
    model_op(VOP_XOR, 5, 5, 4);
    wait_idle();
    check_all();

    // Host read while busy where bank 3 collides with the vs1 read
    issue_cmd(VOP_ADD, 3'd6, 3'd0, 3'd1);
    model_op(VOP_ADD, 6, 0, 1);
    elem_check(2*4+3);
    wait_idle();
    check_all();

    // Host write while busy where bank 2 collides with the vd write
    issue_cmd(VOP_XOR, 3'd6, 3'd1, 3'd0);
    model_op(VOP_XOR, 6, 1, 0);
    elem_write(7*4+2, rand_bits(32), 4'hf);
    wait_idle();
    check_all();

    // Second command lands while the first still runs
    issue_cmd(VOP_SUB, 3'd7, 3'd2, 3'd3);
    model_op(VOP_SUB, 7, 2, 3);
    issue_cmd(VOP_XOR, 3'd4, 3'd0, 3'd1);
    wait_idle();
    check_all();

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+logic
logic/vec_pkg.sv
logic/vec_regfile_bank.sv
logic/vec_vrf.sv
logic/vec_vfu.sv
logic/vec_wb_port.sv
logic/vec_cluster.sv
sim/tb_vec_cluster.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vec_cluster -f all.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb 2>&1)"
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
